/* source/spi_master_pkg.sv */
// shared definitions for the spi master subsystem
// payload and register widths, tx fifo geometry,
// transfer state encoding

`default_nettype none

package spi_master_pkg;

   // ##############################
   // widths
   // ##############################
   localparam int byte_width = 8;   // fifo and serializer payload
   localparam int rx_width   = 64;  // receive shift register
   localparam int div_width  = 8;   // clkdiv_reg and divider counter

   // ##############################
   // tx fifo
   // ##############################
   localparam int fifo_depth      = 8;
   localparam int fifo_addr_width = 3;  // log2 of fifo_depth

   // ##############################
   // transfer states
   // ##############################
   // ss is low in setup, data and hold (automatic mode)
   typedef enum logic [2:0] {
      state_idle   = 3'b000,  // waiting for queued data
      state_setup  = 3'b001,  // ss low, before first edge
      state_data   = 3'b010,  // sclk running
      state_hold   = 3'b011,  // ss low, after last edge
      state_margin = 3'b100   // ss high, gap before next frame
   } state_t;

endpackage

`default_nettype wire

/* source/spi_clock_divider.sv */
// serial clock divider
// free-running counter with period and half-period strobes

`timescale 1ns/1ns
`default_nettype none

module spi_clock_divider (
   input  wire                                   clk,
   input  wire                                   nreset,
   input  wire [spi_master_pkg::div_width-1:0]   clkdiv_reg,  // period is clkdiv_reg+1
   output logic                                  period_match,
   output logic                                  phase_match
);

   logic [spi_master_pkg::div_width-1:0] count;  // position inside the period
   logic [spi_master_pkg::div_width:0]   half_sum;  // one bit wider, clkdiv_reg+1 may be 256
   logic [spi_master_pkg::div_width-1:0] half_point;

   // ##############################
   // counter
   // ##############################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         count <= '0;
      end else if (count == clkdiv_reg) begin
         count <= '0;  // wrap, next cycle is period start
      end else begin
         count <= count + 1'b1;
      end
   end

   // half of the period, rounded down
   assign half_sum   = ({1'b0, clkdiv_reg} + 1'b1) >> 1;
   assign half_point = half_sum[spi_master_pkg::div_width-1:0];

   // ##############################
   // strobes
   // ##############################
   // count zero is the cycle right after the wrap
   assign period_match = (count == '0);
   // never collides with zero as long as clkdiv_reg >= 1
   assign phase_match = (count == half_point);

endmodule

`default_nettype wire

/* source/spi_tx_fifo.sv */
// transmit byte fifo
// circular buffer with occupancy count and registered read port

`timescale 1ns/1ns
`default_nettype none

module spi_tx_fifo (
   input  wire                                    clk,
   input  wire                                    nreset,
   input  wire  [spi_master_pkg::byte_width-1:0]  wr_data,
   input  wire                                    wr_en,
   input  wire                                    rd_en,
   output logic [spi_master_pkg::byte_width-1:0]  rd_data,  // valid cycle after rd_en
   output logic                                   empty,
   output logic                                   full
);

   logic [spi_master_pkg::byte_width-1:0] mem [spi_master_pkg::fifo_depth];

   logic [spi_master_pkg::fifo_addr_width-1:0] wr_ptr;
   logic [spi_master_pkg::fifo_addr_width-1:0] rd_ptr;
   logic [spi_master_pkg::fifo_addr_width:0]   count;  // 0 .. fifo_depth

   logic do_write;
   logic do_read;

   assign do_write = wr_en & ~full;   // write while full is dropped
   assign do_read  = rd_en & ~empty;

   // ##############################
   // storage
   // ##############################
   always_ff @(posedge clk) begin
      if (do_write) begin
         mem[wr_ptr] <= wr_data;
      end
      if (do_read) begin
         rd_data <= mem[rd_ptr];  // one cycle read latency
      end
   end

   // ##############################
   // pointers and occupancy
   // ##############################
   // depth is a power of two, pointers wrap on their own
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_write, do_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // both or neither
         endcase
      end
   end

   assign empty = (count == '0);
   assign full  = (count == (spi_master_pkg::fifo_addr_width + 1)'(spi_master_pkg::fifo_depth));

endmodule

`default_nettype wire

/* source/spi_tx_serializer.sv */
// transmit serializer
// loadable byte shift register, msb or lsb first on dout

`timescale 1ns/1ns
`default_nettype none

module spi_tx_serializer (
   input  wire                                   clk,
   input  wire                                   nreset,
   input  wire [spi_master_pkg::byte_width-1:0]  din,
   input  wire                                   load,      // wins over shift
   input  wire                                   shift,     // launch strobe
   input  wire                                   lsbfirst,
   output logic                                  dout,
   output logic                                  busy
);

   logic [spi_master_pkg::byte_width-1:0]           sreg;
   logic [$clog2(spi_master_pkg::byte_width+1)-1:0] bit_cnt;  // bits left incl. head

   // ##############################
   // shift register
   // ##############################
   always_ff @(posedge clk) begin
      if (load) begin
         sreg <= din;
      end else if (shift) begin
         if (lsbfirst) begin
            sreg <= {1'b0, sreg[spi_master_pkg::byte_width-1:1]};
         end else begin
            sreg <= {sreg[spi_master_pkg::byte_width-2:0], 1'b0};
         end
      end
   end

   // ##############################
   // bit counter
   // ##############################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         bit_cnt <= '0;
      end else if (load) begin
         bit_cnt <= ($bits(bit_cnt))'(spi_master_pkg::byte_width);
      end else if (shift && bit_cnt != '0) begin
         bit_cnt <= bit_cnt - 1'b1;
      end
   end

   assign dout = lsbfirst ? sreg[0] : sreg[spi_master_pkg::byte_width-1];  // head bit

   // high while more than the head bit is left,
   // lets the next byte load right on the last launch
   assign busy = |bit_cnt[$bits(bit_cnt)-1:1];

endmodule

`default_nettype wire

/* source/spi_rx_deserializer.sv */
// receive deserializer
// 64-bit shift register fed one miso bit per sample strobe

`timescale 1ns/1ns
`default_nettype none

module spi_rx_deserializer (
   input  wire                                   clk,
   input  wire                                   nreset,
   input  wire                                   din,       // sampled miso
   input  wire                                   shift,     // sample strobe
   input  wire                                   lsbfirst,
   output logic [spi_master_pkg::rx_width-1:0]   dout
);

   // contents are kept from frame to frame
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         dout <= '0;
      end else if (shift) begin
         if (lsbfirst) begin
            // first bit ends up lowest after a full fill
            dout <= {din, dout[spi_master_pkg::rx_width-1:1]};
         end else begin
            dout <= {dout[spi_master_pkg::rx_width-2:0], din};  // new bit at 0
         end
      end
   end

endmodule

`default_nettype wire

/* source/spi_master_io.sv */
// spi master transfer engine
// five-state transfer fsm, launch and sample strobe selection,
// sclk and ss pin generation, rx_access pulse
// tx serializer and rx deserializer instances

`timescale 1ns/1ns
`default_nettype none

module spi_master_io (
   input  wire                                    clk,
   input  wire                                    nreset,
   input  wire                                    cpol,
   input  wire                                    cpha,
   input  wire                                    lsbfirst,
   input  wire                                    manual_mode,
   input  wire                                    send_data,     // ss level in manual mode
   input  wire                                    period_match,
   input  wire                                    phase_match,
   input  wire  [spi_master_pkg::byte_width-1:0]  fifo_dout,
   input  wire                                    fifo_empty,
   output logic                                   fifo_read,
   output spi_master_pkg::state_t                 spi_state,
   output logic [spi_master_pkg::rx_width-1:0]    rx_data,
   output logic                                   rx_access,     // one cycle after ss rises
   output logic                                   sclk,
   output logic                                   mosi,
   output logic                                   ss,            // active low
   input  wire                                    miso
);

   logic in_data;     // sclk running
   logic active;      // frame open in automatic mode
   logic tx_busy;
   logic load_byte;
   logic tx_fresh;    // byte loaded, first launch edge still ahead
   logic launch_pm;
   logic tx_shift;
   logic rx_shift;
   logic data_done;
   logic sclk_reg;
   logic ss_reg;

   assign in_data = (spi_state == spi_master_pkg::state_data);

   // ##############################
   // transfer fsm
   // ##############################
   // reads only when idle or mid-stream, never in setup, hold or margin
   assign fifo_read = ~fifo_empty & ~tx_busy & phase_match &
                      (in_data | (spi_state == spi_master_pkg::state_idle));

   assign data_done = fifo_empty & ~tx_busy & phase_match;  // queue drained

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         spi_state <= spi_master_pkg::state_idle;
      end else begin
         case (spi_state)
            spi_master_pkg::state_idle:
               if (fifo_read) spi_state <= spi_master_pkg::state_setup;
            spi_master_pkg::state_setup:
               if (phase_match) spi_state <= spi_master_pkg::state_data;
            spi_master_pkg::state_data:
               if (data_done) spi_state <= spi_master_pkg::state_hold;
            spi_master_pkg::state_hold:
               if (phase_match) spi_state <= spi_master_pkg::state_margin;
            spi_master_pkg::state_margin:
               if (phase_match) spi_state <= spi_master_pkg::state_idle;
            default:
               spi_state <= spi_master_pkg::state_idle;
         endcase
      end
   end

   // fifo_dout arrives one cycle after the read
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         load_byte <= 1'b0;
      end else begin
         load_byte <= fifo_read;
      end
   end

   // ##############################
   // launch and sample edges
   // ##############################
   assign launch_pm = in_data & period_match;  // leading edge in data

   // cpha 1 presents the head bit at load, so the first leading edge
   // after a load must not shift. a load on that very edge counts as it
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         tx_fresh <= 1'b0;
      end else if (load_byte) begin
         tx_fresh <= ~launch_pm;
      end else if (launch_pm) begin
         tx_fresh <= 1'b0;
      end
   end

   assign tx_shift = cpha ? (launch_pm & ~tx_fresh)      // launch on leading
                          : (in_data & phase_match);     // launch on trailing
   assign rx_shift = in_data & (cpha ? phase_match : period_match);

   spi_tx_serializer tx0 (
      .clk      (clk),
      .nreset   (nreset),
      .din      (fifo_dout),
      .load     (load_byte),
      .shift    (tx_shift),
      .lsbfirst (lsbfirst),
      .dout     (mosi),
      .busy     (tx_busy)
   );

   spi_rx_deserializer rx0 (
      .clk      (clk),
      .nreset   (nreset),
      .din      (miso),
      .shift    (rx_shift),
      .lsbfirst (lsbfirst),
      .dout     (rx_data)
   );

   // ##############################
   // sclk
   // ##############################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         sclk_reg <= 1'b0;
      end else if (launch_pm) begin
         sclk_reg <= 1'b1;           // leading edge
      end else if (in_data & phase_match) begin
         sclk_reg <= 1'b0;           // trailing edge
      end
   end

   assign sclk = sclk_reg ^ cpol;  // idle level follows cpol

   // ##############################
   // slave select and done pulse
   // ##############################
   assign active = (spi_state == spi_master_pkg::state_setup) | in_data |
                   (spi_state == spi_master_pkg::state_hold);

   assign ss = ~((active & ~manual_mode) | (send_data & manual_mode));

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         ss_reg    <= 1'b1;
         rx_access <= 1'b0;
      end else begin
         ss_reg    <= ss;
         rx_access <= ss & ~ss_reg;  // registered rise detect
      end
   end

endmodule

`default_nettype wire

/* source/spi_master.sv */
// spi master top level
// tx fifo, clock divider and transfer engine wired to the pins

`timescale 1ns/1ns
`default_nettype none

module spi_master (
   input  wire                                    clk,
   input  wire                                    nreset,
   // tx write port
   input  wire  [spi_master_pkg::byte_width-1:0]  tx_data,
   input  wire                                    tx_write,
   output logic                                   tx_full,
   // configuration, stable during a transfer
   input  wire  [spi_master_pkg::div_width-1:0]   clkdiv_reg,
   input  wire                                    cpol,
   input  wire                                    cpha,
   input  wire                                    lsbfirst,
   input  wire                                    manual_mode,
   input  wire                                    send_data,
   // receive side and status
   output logic [spi_master_pkg::rx_width-1:0]    rx_data,
   output logic                                   rx_access,
   output spi_master_pkg::state_t                 spi_state,
   // spi pins
   output logic                                   sclk,
   output logic                                   mosi,
   output logic                                   ss,
   input  wire                                    miso
);

   logic                                  period_match;
   logic                                  phase_match;
   logic                                  fifo_read;
   logic                                  fifo_empty;
   logic [spi_master_pkg::byte_width-1:0] fifo_dout;

   spi_clock_divider div0 (
      .clk          (clk),
      .nreset       (nreset),
      .clkdiv_reg   (clkdiv_reg),
      .period_match (period_match),
      .phase_match  (phase_match)
   );

   spi_tx_fifo fifo0 (
      .clk     (clk),
      .nreset  (nreset),
      .wr_data (tx_data),
      .wr_en   (tx_write),
      .rd_en   (fifo_read),
      .rd_data (fifo_dout),
      .empty   (fifo_empty),
      .full    (tx_full)
   );

   spi_master_io io0 (
      .clk          (clk),
      .nreset       (nreset),
      .cpol         (cpol),
      .cpha         (cpha),
      .lsbfirst     (lsbfirst),
      .manual_mode  (manual_mode),
      .send_data    (send_data),
      .period_match (period_match),
      .phase_match  (phase_match),
      .fifo_dout    (fifo_dout),
      .fifo_empty   (fifo_empty),
      .fifo_read    (fifo_read),
      .spi_state    (spi_state),
      .rx_data      (rx_data),
      .rx_access    (rx_access),
      .sclk         (sclk),
      .mosi         (mosi),
      .ss           (ss),
      .miso         (miso)
   );

endmodule

`default_nettype wire

/* verification/spi_slave_model.sv */
// behavioral spi slave for the master testbench
// collects mosi bytes per frame, shifts out a 64-bit miso pattern
// edges taken from cpol and cpha, bit order from lsbfirst

`timescale 1ns/1ns
`default_nettype none

module spi_slave_model (
   input  wire          sclk,
   input  wire          ss,            // active low
   input  wire          mosi,
   input  wire          cpol,
   input  wire          cpha,
   input  wire          lsbfirst,
   input  wire  [63:0]  miso_pattern,  // bit 0 goes out first
   output logic         miso
);

   logic [7:0] rx_bytes [16];  // bytes of the current frame
   int         byte_count;
   int         bit_count;
   int         idx;                // next pattern bit
   logic [7:0] shreg;
   logic       leading;

   initial begin
      miso       = 1'b0;
      byte_count = 0;
      bit_count  = 0;
      idx        = 0;
      shreg      = 8'h00;
   end

   // frame start, first bit out before any edge
   always @(negedge ss) begin
      byte_count = 0;
      bit_count  = 0;
      idx        = 0;
      miso       = miso_pattern[0];
   end

   // ##############################
   // sclk edges
   // ##############################
   always @(sclk) begin
      if (ss === 1'b0) begin
         leading = (sclk != cpol);  // away from idle level
         // cpha 0 samples on leading, cpha 1 on trailing
         if (leading == !cpha) begin
            if (lsbfirst) begin
               shreg = {mosi, shreg[7:1]};
            end else begin
               shreg = {shreg[6:0], mosi};
            end
            bit_count++;
            if (bit_count == 8) begin
               if (byte_count < 16) begin
                  rx_bytes[byte_count] = shreg;
               end
               byte_count++;
               bit_count = 0;
            end
         end else if (cpha) begin
            miso = miso_pattern[idx % 64];  // launch on leading
            idx++;
         end else begin
            idx++;                           // launch on trailing
            miso = miso_pattern[idx % 64];
         end
      end
   end

endmodule

`default_nettype wire

/* verification/spi_master_tb.sv */
// testbench for the spi master subsystem
// row table of bus settings applied in a loop, fifo writes,
// slave model byte checks, rx_data model, sclk and rx_access monitors

`timescale 1ns/1ns
`default_nettype none

module spi_master_tb;

   typedef struct packed {
      logic [7:0] clkdiv;
      logic       cpol;
      logic       cpha;
      logic       lsbfirst;
      logic       manual;
      logic       overfill;  // write until tx_full, then one more
      logic [3:0] nbytes;
   } row_t;

   localparam int n_rows = 12;

   logic                                  clk;
   logic                                  nreset;
   logic [spi_master_pkg::byte_width-1:0] tx_data;
   logic                                  tx_write;
   logic                                  tx_full;
   logic [spi_master_pkg::div_width-1:0]  clkdiv_reg;
   logic                                  cpol;
   logic                                  cpha;
   logic                                  lsbfirst;
   logic                                  manual_mode;
   logic                                  send_data;
   logic [spi_master_pkg::rx_width-1:0]   rx_data;
   logic                                  rx_access;
   spi_master_pkg::state_t                spi_state;
   logic                                  sclk;
   logic                                  mosi;
   logic                                  ss;
   logic                                  miso;
   logic [63:0]                           miso_pattern;

   row_t        rows [n_rows];
   logic [7:0]  sent_q [$];       // bytes accepted by the fifo, in order
   logic [63:0] exp_rx = '0;      // deserializer model, kept across rows
   int          errors = 0;
   int          pass_count = 0;
   int          fail_count = 0;
   logic        hung = 1'b0;

   // monitor state
   int unsigned cycle = 0;
   int unsigned ss_rise_cycle = 0;
   int unsigned last_lead = 0;
   logic        have_lead = 1'b0;
   logic        ss_prev = 1'b1;
   logic        sclk_prev = 1'b0;

   spi_master dut0 (
      .clk(clk), .nreset(nreset),
      .tx_data(tx_data), .tx_write(tx_write), .tx_full(tx_full),
      .clkdiv_reg(clkdiv_reg), .cpol(cpol), .cpha(cpha), .lsbfirst(lsbfirst),
      .manual_mode(manual_mode), .send_data(send_data),
      .rx_data(rx_data), .rx_access(rx_access), .spi_state(spi_state),
      .sclk(sclk), .mosi(mosi), .ss(ss), .miso(miso)
   );

   spi_slave_model slave0 (
      .sclk(sclk), .ss(ss), .mosi(mosi), .cpol(cpol), .cpha(cpha),
      .lsbfirst(lsbfirst), .miso_pattern(miso_pattern), .miso(miso)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;  // 8 ns period

   always @(posedge clk) cycle++;

   function automatic void report_mismatch(input string name, input logic [63:0] expected,
                                           input logic [63:0] actual);
      $display("error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
      errors++;
   endfunction

   // ##############################
   // pin monitors
   // ##############################
   always @(negedge clk) begin
      if (nreset) begin
         if (ss && !ss_prev) ss_rise_cycle = cycle;
         if (rx_access && cycle != ss_rise_cycle + 1)
            report_mismatch("rx_access delay", 1, cycle - ss_rise_cycle);
         if (manual_mode && send_data && ss) report_mismatch("ss", 0, ss);
         if (ss && sclk != cpol) report_mismatch("sclk", cpol, sclk);  // idle level
         if (ss) begin
            have_lead = 1'b0;
         end else if (sclk != sclk_prev && sclk != cpol) begin
            // leading edge, spacing is one full divider period
            if (have_lead && cycle - last_lead != clkdiv_reg + 1)
               report_mismatch("sclk period", clkdiv_reg + 1, cycle - last_lead);
            have_lead = 1'b1;
            last_lead = cycle;
         end
      end
      ss_prev   = ss;
      sclk_prev = sclk;
   end

   // ##############################
   // stimulus helpers
   // ##############################
   task automatic fill_table();
      //            div     cpol  cpha  lsb   man   over  bytes
      rows[0]  = '{8'd2,   1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 4'd1};
      rows[1]  = '{8'd3,   1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 4'd2};
      rows[2]  = '{8'd4,   1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 4'd3};
      rows[3]  = '{8'd5,   1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 4'd4};
      rows[4]  = '{8'd2,   1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 4'd8};
      rows[5]  = '{8'd7,   1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 4'd8};
      rows[6]  = '{8'd3,   1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 4'd5};
      rows[7]  = '{8'd6,   1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 4'd6};
      rows[8]  = '{8'd2,   1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 4'd2};  // manual ss
      rows[9]  = '{8'd4,   1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 4'd3};  // manual ss
      rows[10] = '{8'd255, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 4'd8};  // fifo limit
      rows[11] = '{8'd3,   1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 4'd1};
   endtask

   task automatic write_byte(input logic [7:0] value);
      @(posedge clk);
      #1;
      tx_data  = value;
      tx_write = 1'b1;
      sent_q.push_back(value);
   endtask

   task automatic end_writes();
      @(posedge clk);
      #1;
      tx_write = 1'b0;
   endtask

   // back to back writes until tx_full, then one write that must be dropped
   task automatic fill_fifo();
      int         accepted;
      int         drained;
      logic       full_seen;
      logic [7:0] value;
      accepted  = 0;
      full_seen = 1'b0;
      while (!full_seen && accepted < spi_master_pkg::fifo_depth + 2) begin
         @(posedge clk);
         #1;
         value   = 8'($urandom);
         tx_data = value;
         tx_write = 1'b1;
         if (tx_full) begin
            full_seen = 1'b1;
            // leaving idle means exactly one byte was already read
            drained = (spi_state != spi_master_pkg::state_idle) ? 1 : 0;
            if (accepted != spi_master_pkg::fifo_depth + drained)
               report_mismatch("writes until tx_full", spi_master_pkg::fifo_depth + drained,
                               accepted);
         end else begin
            sent_q.push_back(value);
            accepted++;
         end
      end
      if (!full_seen) begin
         $display("tx_full never rose after %0d accepted writes", accepted);
         errors++;
      end
      end_writes();
   endtask

   // ##############################
   // bounded waits, sampled at negedge
   // ##############################
   task automatic wait_for_state(input spi_master_pkg::state_t target, input int limit,
                                 input string what);
      int n;
      n = 0;
      if (!hung) begin
         @(negedge clk);
         while (spi_state != target && n < limit) begin
            @(negedge clk);
            n++;
         end
         if (spi_state != target) begin
            $display("timeout at %0t ns: no %s within %0d cycles", $time, what, limit);
            hung = 1'b1;
         end
      end
   endtask

   task automatic wait_for_rx_access(input int limit);
      int n;
      n = 0;
      if (!hung) begin
         @(negedge clk);
         while (!rx_access && n < limit) begin
            @(negedge clk);
            n++;
         end
         if (!rx_access) begin
            $display("timeout at %0t ns: rx_access never pulsed within %0d cycles", $time, limit);
            hung = 1'b1;
         end
      end
   endtask

   // ##############################
   // one table row
   // ##############################
   task automatic run_row(input int idx);
      row_t        r;
      int          errors_before;
      int          limit;
      int          k;
      logic [63:0] pattern;
      r = rows[idx];
      errors_before = errors;
      pattern = {$urandom, $urandom};
      sent_q.delete();
      @(posedge clk);
      #1;
      clkdiv_reg   = r.clkdiv;
      cpol         = r.cpol;
      cpha         = r.cpha;
      lsbfirst     = r.lsbfirst;
      manual_mode  = r.manual;
      send_data    = 1'b0;
      miso_pattern = pattern;
      if (r.manual) begin
         @(posedge clk);
         #1;
         send_data = 1'b1;  // ss low from here
      end
      if (r.overfill) begin
         fill_fifo();
      end else begin
         for (k = 0; k < r.nbytes; k++) write_byte(8'($urandom));
         end_writes();
      end
      limit = (sent_q.size() + 4) * 8 * (r.clkdiv + 1) + 600;
      if (r.manual) begin
         wait_for_state(spi_master_pkg::state_margin, limit, "frame end with manual ss");
         wait_for_state(spi_master_pkg::state_idle, limit, "return to idle with manual ss");
         repeat (2 * (r.clkdiv + 1)) @(posedge clk);  // idle gap, ss must stay low
         #1;
         send_data = 1'b0;
      end
      wait_for_rx_access(limit);
      if (!hung) begin
         // deserializer rule over the bits the slave sent
         for (k = 0; k < 8 * sent_q.size(); k++) begin
            if (r.lsbfirst) exp_rx = {pattern[k % 64], exp_rx[63:1]};
            else exp_rx = {exp_rx[62:0], pattern[k % 64]};
         end
         if (rx_data !== exp_rx) report_mismatch("rx_data", exp_rx, rx_data);
         if (slave0.byte_count != sent_q.size()) begin
            report_mismatch("slave byte count", sent_q.size(), slave0.byte_count);
         end else begin
            for (k = 0; k < sent_q.size(); k++)
               if (slave0.rx_bytes[k] !== sent_q[k])
                  report_mismatch($sformatf("slave byte %0d", k), sent_q[k], slave0.rx_bytes[k]);
         end
         wait_for_state(spi_master_pkg::state_idle, limit, "idle after rx_access");
      end
      if (errors == errors_before && !hung) pass_count++;
      else fail_count++;
      $display("row %0d: div %0d cpol %0d cpha %0d lsb %0d manual %0d bytes %0d: %s",
               idx, r.clkdiv, r.cpol, r.cpha, r.lsbfirst, r.manual, sent_q.size(),
               (errors == errors_before && !hung) ? "ok" : "fail");
   endtask

   // ##############################
   // main sequence
   // ##############################
   initial begin
      int          i;
      int          errors_before;
      void'($urandom(32'hbb09a357));  // one seed for the whole run
      nreset       = 1'b0;
      tx_data      = '0;
      tx_write     = 1'b0;
      clkdiv_reg   = 8'd2;
      cpol         = 1'b0;
      cpha         = 1'b0;
      lsbfirst     = 1'b0;
      manual_mode  = 1'b0;
      send_data    = 1'b0;
      miso_pattern = '0;
      fill_table();
      repeat (2) @(posedge clk);
      #1;
      nreset = 1'b1;

      // state right after reset
      @(negedge clk);
      errors_before = errors;
      if (ss !== 1'b1) report_mismatch("ss", 1, ss);
      if (sclk !== cpol) report_mismatch("sclk", cpol, sclk);
      if (rx_access !== 1'b0) report_mismatch("rx_access", 0, rx_access);
      if (tx_full !== 1'b0) report_mismatch("tx_full", 0, tx_full);
      if (spi_state !== spi_master_pkg::state_idle)
         report_mismatch("spi_state", spi_master_pkg::state_idle, spi_state);
      if (errors == errors_before) pass_count++;
      else fail_count++;
      $display("reset: %s", (errors == errors_before) ? "ok" : "fail");

      for (i = 0; i < n_rows; i++) begin
         run_row(i);
         if (hung) break;
      end

      $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, errors);
      if (errors == 0 && fail_count == 0 && !hung) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* spi_master.f */
source/spi_master_pkg.sv
source/spi_clock_divider.sv
source/spi_tx_fifo.sv
source/spi_tx_serializer.sv
source/spi_rx_deserializer.sv
source/spi_master_io.sv
source/spi_master.sv
verification/spi_slave_model.sv
verification/spi_master_tb.sv

/* Bender.yml */
package:
  name: spi_master

sources:
  # package first, then leaf modules up to the top level
  - source/spi_master_pkg.sv
  - source/spi_clock_divider.sv
  - source/spi_tx_fifo.sv
  - source/spi_tx_serializer.sv
  - source/spi_rx_deserializer.sv
  - source/spi_master_io.sv
  - source/spi_master.sv

  # testbench, top module spi_master_tb
  - target: test
    files:
      - verification/spi_slave_model.sv
      - verification/spi_master_tb.sv
